//--- source/cpuPkg.sv
package cpuPkg;

    localparam int xlen = 32;
    localparam int regAddrBits = 5;
    localparam int imemWords = 128;
    localparam int dmemWords = 64;
    localparam int memIdxBits = $clog2(imemWords);   // wide enough for either memory
    localparam int apbAddrBits = 12;

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opAluImm = 7'b0010011;
    localparam logic [6:0] opAluReg = 7'b0110011;

    localparam logic [2:0] f3Add  = 3'b000;   // also SUB
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;   // also SRA
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [2:0] f3Word = 3'b010;   // only LW and SW are supported
    localparam logic [6:0] f7Alt  = 7'b0100000;

    // APB byte addresses, memory bases sit on 512 byte boundaries
    localparam logic [apbAddrBits-1:0] imemBase = 12'h000;
    localparam logic [apbAddrBits-1:0] dmemBase = 12'h400;
    localparam logic [apbAddrBits-1:0] ctrlAddr = 12'h800;
    localparam logic [apbAddrBits-1:0] pcAddr   = 12'h804;

    typedef logic [xlen-1:0] word_t;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [regAddrBits-1:0] rd;
        logic [regAddrBits-1:0] rs1;
        logic [regAddrBits-1:0] rs2;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        word_t                  immI;
        word_t                  immS;
        word_t                  immB;
        word_t                  immU;
        word_t                  immJ;
        logic                   badOpcode;
    } decoded_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [apbAddrBits-1:0] paddr;
        word_t                  pwdata;
    } apbReq_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apbRsp_t;

    typedef struct packed {
        logic [memIdxBits-1:0] idx;   // word index, not byte address
        word_t                 wdata;
        logic                  wen;
    } memReq_t;

endpackage

//--- source/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  cpuPkg::word_t    instr,
    output cpuPkg::decoded_t dec
);

    always_comb begin
        dec.opcode = instr[6:0];
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct7 = instr[31:25];

        dec.immI = {{20{instr[31]}}, instr[31:20]};
        dec.immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        dec.immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.immU = {instr[31:12], 12'b0};
        dec.immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

        case (instr[6:0])
            cpuPkg::opLui,
            cpuPkg::opAuipc,
            cpuPkg::opJal,
            cpuPkg::opJalr,
            cpuPkg::opBranch,
            cpuPkg::opLoad,
            cpuPkg::opStore,
            cpuPkg::opAluImm,
            cpuPkg::opAluReg: dec.badOpcode = 1'b0;
            default:          dec.badOpcode = 1'b1;   // includes all-zero and all-one words
        endcase
    end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpuPkg::regAddrBits-1:0] rs1Addr,
    input  logic [cpuPkg::regAddrBits-1:0] rs2Addr,
    input  logic [cpuPkg::regAddrBits-1:0] rdAddr,
    input  cpuPkg::word_t                  rdData,
    input  logic                           rdWen,
    output cpuPkg::word_t                  rs1Data,
    output cpuPkg::word_t                  rs2Data
);

    cpuPkg::word_t regs [2**cpuPkg::regAddrBits];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**cpuPkg::regAddrBits; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWen && rdAddr != '0) begin   // x0 stays zero
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

//--- source/aluExec.sv
`timescale 1ns/1ps

module aluExec (
    input  cpuPkg::decoded_t dec,
    input  cpuPkg::word_t    rs1Data,
    input  cpuPkg::word_t    rs2Data,
    output cpuPkg::word_t    result,
    output logic             illegal
);

    logic          isReg;
    logic          isAlu;
    logic          isShift;
    logic          f7Zero;
    logic          f7IsAlt;
    logic          altAllowed;
    logic [4:0]    shamt;
    cpuPkg::word_t opB;

    assign isReg = dec.opcode == cpuPkg::opAluReg;
    assign isAlu = isReg || dec.opcode == cpuPkg::opAluImm;
    assign opB   = isReg ? rs2Data : dec.immI;
    assign shamt = opB[4:0];   // immI[4:0] is the shamt field for the immediate form

    // for shift-immediates funct7 lines up with immI[11:5]
    assign f7Zero  = dec.funct7 == 7'b0;
    assign f7IsAlt = dec.funct7 == cpuPkg::f7Alt;

    always_comb begin
        case (dec.funct3)
            cpuPkg::f3Add: begin
                if (isReg && f7IsAlt) begin
                    result = rs1Data - opB;
                end else begin
                    result = rs1Data + opB;
                end
            end
            cpuPkg::f3Sll:  result = rs1Data << shamt;
            cpuPkg::f3Slt:  result = {31'b0, $signed(rs1Data) < $signed(opB)};
            cpuPkg::f3Sltu: result = {31'b0, rs1Data < opB};
            cpuPkg::f3Xor:  result = rs1Data ^ opB;
            cpuPkg::f3Srl: begin
                if (f7IsAlt) begin
                    result = $signed(rs1Data) >>> shamt;   // SRA / SRAI
                end else begin
                    result = rs1Data >> shamt;
                end
            end
            cpuPkg::f3Or:   result = rs1Data | opB;
            default:        result = rs1Data & opB;   // f3And
        endcase
    end

    // upper bits only matter for register forms and the two shift immediates
    assign isShift    = dec.funct3 == cpuPkg::f3Sll || dec.funct3 == cpuPkg::f3Srl;
    assign altAllowed = dec.funct3 == cpuPkg::f3Srl || (isReg && dec.funct3 == cpuPkg::f3Add);
    assign illegal    = isAlu && (isReg || isShift) && !(f7Zero || (f7IsAlt && altAllowed));

endmodule

//--- source/nextPc.sv
`timescale 1ns/1ps

module nextPc (
    input  cpuPkg::decoded_t dec,
    input  cpuPkg::word_t    pc,
    input  cpuPkg::word_t    rs1Data,
    input  cpuPkg::word_t    rs2Data,
    output cpuPkg::word_t    pcNext,
    output cpuPkg::word_t    linkAddr,
    output logic             illegal
);

    logic          taken;
    logic          badBranchF3;
    cpuPkg::word_t jalrSum;

    always_comb begin
        badBranchF3 = 1'b0;
        case (dec.funct3)
            cpuPkg::f3Beq:  taken = rs1Data == rs2Data;
            cpuPkg::f3Bne:  taken = rs1Data != rs2Data;
            cpuPkg::f3Blt:  taken = $signed(rs1Data) < $signed(rs2Data);
            cpuPkg::f3Bge:  taken = $signed(rs1Data) >= $signed(rs2Data);
            cpuPkg::f3Bltu: taken = rs1Data < rs2Data;
            cpuPkg::f3Bgeu: taken = rs1Data >= rs2Data;
            default: begin   // 010 and 011
                taken = 1'b0;
                badBranchF3 = 1'b1;
            end
        endcase
    end

    assign linkAddr = pc + 32'd4;
    assign jalrSum  = rs1Data + dec.immI;

    always_comb begin
        case (dec.opcode)
            cpuPkg::opBranch: pcNext = taken ? pc + dec.immB : linkAddr;
            cpuPkg::opJal:    pcNext = pc + dec.immJ;
            cpuPkg::opJalr:   pcNext = {jalrSum[31:1], 1'b0};
            default:          pcNext = linkAddr;
        endcase
    end

    assign illegal = (dec.opcode == cpuPkg::opBranch && badBranchF3) ||
                     (dec.opcode == cpuPkg::opJalr && dec.funct3 != 3'b000);

endmodule

//--- source/wordMem.sv
`timescale 1ns/1ps

module wordMem #(
    parameter int depth = 64
) (
    input  logic             clk,
    input  cpuPkg::memReq_t  req,
    output cpuPkg::word_t    rdata
);

    cpuPkg::word_t              mem [depth];
    logic [$clog2(depth)-1:0]   idx;

    // upper index bits drop off, so addresses wrap at the memory size
    assign idx = req.idx[$clog2(depth)-1:0];

    always_ff @(posedge clk) begin
        if (req.wen) begin
            mem[idx] <= req.wdata;
        end
    end

    assign rdata = mem[idx];   // async read

endmodule

//--- source/apbRegs.sv
`timescale 1ns/1ps

module apbRegs (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::apbReq_t apbIn,
    output cpuPkg::apbRsp_t apbOut,
    input  logic            halted,
    input  cpuPkg::word_t   pc,
    input  cpuPkg::memReq_t coreImemReq,
    input  cpuPkg::memReq_t coreDmemReq,
    output cpuPkg::memReq_t imemReq,
    output cpuPkg::memReq_t dmemReq,
    input  cpuPkg::word_t   imemData,
    input  cpuPkg::word_t   dmemData,
    output logic            step,
    output logic            start
);

    logic run;
    logic access;
    logic wrAccess;
    logic imemHit;
    logic dmemHit;
    logic ctrlHit;
    logic pcHit;
    logic slvErr;

    assign access   = apbIn.psel && apbIn.penable;   // second cycle of the transfer
    assign wrAccess = access && apbIn.pwrite;

    assign imemHit = apbIn.paddr >= cpuPkg::imemBase &&
                     apbIn.paddr < cpuPkg::imemBase + cpuPkg::imemWords * 4;
    assign dmemHit = apbIn.paddr >= cpuPkg::dmemBase &&
                     apbIn.paddr < cpuPkg::dmemBase + cpuPkg::dmemWords * 4;
    assign ctrlHit = apbIn.paddr == cpuPkg::ctrlAddr;
    assign pcHit   = apbIn.paddr == cpuPkg::pcAddr;

    always_ff @(posedge clk) begin
        if (!rst) begin
            run <= 1'b0;
        end else if (wrAccess && ctrlHit) begin
            run <= apbIn.pwdata[0];
        end
    end

    assign start = wrAccess && ctrlHit && apbIn.pwdata[0];
    assign step  = run && !halted;

    // bus owns both memories only while stopped
    always_comb begin
        imemReq = coreImemReq;
        dmemReq = coreDmemReq;
        if (!run) begin
            imemReq.idx   = apbIn.paddr[cpuPkg::memIdxBits+1:2];   // bases are 512 byte aligned
            imemReq.wdata = apbIn.pwdata;
            imemReq.wen   = wrAccess && imemHit;
            dmemReq.idx   = apbIn.paddr[cpuPkg::memIdxBits+1:2];
            dmemReq.wdata = apbIn.pwdata;
            dmemReq.wen   = wrAccess && dmemHit;
        end
    end

    assign slvErr = !(imemHit || dmemHit || ctrlHit || pcHit) ||
                    (run && (imemHit || dmemHit)) ||
                    (pcHit && apbIn.pwrite);

    always_comb begin
        apbOut.pready  = 1'b1;   // no wait states
        apbOut.pslverr = access && slvErr;
        if (imemHit) begin
            apbOut.prdata = imemData;
        end else if (dmemHit) begin
            apbOut.prdata = dmemData;
        end else if (ctrlHit) begin
            apbOut.prdata = {30'b0, halted, run};
        end else if (pcHit) begin
            apbOut.prdata = pc;
        end else begin
            apbOut.prdata = '0;
        end
    end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic            clk,
    input  logic            rst,
    input  logic            step,
    input  logic            start,
    input  cpuPkg::word_t   instr,
    input  cpuPkg::word_t   dmemData,
    output cpuPkg::memReq_t imemReq,
    output cpuPkg::memReq_t dmemReq,
    output cpuPkg::word_t   pc,
    output logic            halted
);

    cpuPkg::decoded_t dec;
    cpuPkg::word_t    rs1Data;
    cpuPkg::word_t    rs2Data;
    cpuPkg::word_t    rdData;
    cpuPkg::word_t    aluResult;
    cpuPkg::word_t    pcNextVal;
    cpuPkg::word_t    linkAddr;
    cpuPkg::word_t    dataAddr;
    logic             aluIllegal;
    logic             pcIllegal;
    logic             isLoad;
    logic             isStore;
    logic             memIllegal;
    logic             targetMisaligned;
    logic             illegal;
    logic             retire;
    logic             writesRd;

    instrDecode i_instrDecode (
        .instr (instr),
        .dec   (dec)
    );

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (dec.rs1),
        .rs2Addr (dec.rs2),
        .rdAddr  (dec.rd),
        .rdData  (rdData),
        .rdWen   (retire && writesRd),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    aluExec i_aluExec (
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .result  (aluResult),
        .illegal (aluIllegal)
    );

    nextPc i_nextPc (
        .dec      (dec),
        .pc       (pc),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .pcNext   (pcNextVal),
        .linkAddr (linkAddr),
        .illegal  (pcIllegal)
    );

    assign isLoad   = dec.opcode == cpuPkg::opLoad;
    assign isStore  = dec.opcode == cpuPkg::opStore;
    assign dataAddr = rs1Data + (isStore ? dec.immS : dec.immI);

    // word accesses only
    assign memIllegal = (isLoad || isStore) &&
                        (dec.funct3 != cpuPkg::f3Word || dataAddr[1:0] != 2'b00);
    assign targetMisaligned = pcNextVal[1:0] != 2'b00;   // JALR with bit 1 set lands here

    assign illegal = dec.badOpcode || aluIllegal || pcIllegal || memIllegal || targetMisaligned;
    assign retire  = step && !illegal;

    assign writesRd = !(isStore || dec.opcode == cpuPkg::opBranch);

    always_comb begin
        case (dec.opcode)
            cpuPkg::opLui:   rdData = dec.immU;
            cpuPkg::opAuipc: rdData = pc + dec.immU;
            cpuPkg::opJal,
            cpuPkg::opJalr:  rdData = linkAddr;
            cpuPkg::opLoad:  rdData = dmemData;
            default:         rdData = aluResult;
        endcase
    end

    always_comb begin
        imemReq.idx   = pc[cpuPkg::memIdxBits+1:2];
        imemReq.wdata = '0;
        imemReq.wen   = 1'b0;   // fetch port never writes
        dmemReq.idx   = dataAddr[cpuPkg::memIdxBits+1:2];
        dmemReq.wdata = rs2Data;
        dmemReq.wen   = retire && isStore;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (start) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (retire) begin
            pc <= pcNextVal;
        end else if (step) begin
            halted <= 1'b1;   // pc stays on the offending instruction
        end
    end

endmodule

//--- source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::apbReq_t apbIn,
    output cpuPkg::apbRsp_t apbOut
);

    cpuPkg::memReq_t imemReq;
    cpuPkg::memReq_t dmemReq;
    cpuPkg::memReq_t coreImemReq;
    cpuPkg::memReq_t coreDmemReq;
    cpuPkg::word_t   imemData;
    cpuPkg::word_t   dmemData;
    cpuPkg::word_t   pc;
    logic            halted;
    logic            step;
    logic            start;

    apbRegs i_apbRegs (
        .clk         (clk),
        .rst         (rst),
        .apbIn       (apbIn),
        .apbOut      (apbOut),
        .halted      (halted),
        .pc          (pc),
        .coreImemReq (coreImemReq),
        .coreDmemReq (coreDmemReq),
        .imemReq     (imemReq),
        .dmemReq     (dmemReq),
        .imemData    (imemData),
        .dmemData    (dmemData),
        .step        (step),
        .start       (start)
    );

    cpuCore i_cpuCore (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .start    (start),
        .instr    (imemData),
        .dmemData (dmemData),
        .imemReq  (coreImemReq),
        .dmemReq  (coreDmemReq),
        .pc       (pc),
        .halted   (halted)
    );

    wordMem #(.depth(cpuPkg::imemWords)) i_imem (
        .clk   (clk),
        .req   (imemReq),
        .rdata (imemData)
    );

    wordMem #(.depth(cpuPkg::dmemWords)) i_dmem (
        .clk   (clk),
        .req   (dmemReq),
        .rdata (dmemData)
    );

endmodule

//--- bench/cpuAssert_assert.sv
`timescale 1ns/1ps

module cpuAssert (
    input logic          clk,
    input logic          rst,
    input logic          step,
    input logic          start,
    input logic          halted,
    input cpuPkg::word_t pc,
    input logic          dmemWen
);

    // a halted core keeps its pc until the next start
    pcHeld: assert property (@(posedge clk) disable iff (!rst)
        halted && !start |=> $stable(pc))
        else $error("pc moved while the core was halted");

    noWriteHalted: assert property (@(posedge clk) disable iff (!rst)
        halted |-> !dmemWen)
        else $error("data memory write while the core was halted");

    haltAfterStep: assert property (@(posedge clk) disable iff (!rst)
        $rose(halted) |-> $past(step))
        else $error("halted rose without a step in the cycle before");

endmodule

bind cpuCore cpuAssert i_cpuAssert (
    .clk     (clk),
    .rst     (rst),
    .step    (step),
    .start   (start),
    .halted  (halted),
    .pc      (pc),
    .dmemWen (dmemReq.wen)
);

//--- bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra, aluOr, aluAnd,
        brEq, brNe, brLt, brGe, brLtu, brGeu, jmpJal, jmpJalr, upAuipc
    } opKind_e;

    typedef struct packed {
        opKind_e       kind;
        logic          useImm;
        cpuPkg::word_t a;
        cpuPkg::word_t b;   // already the effective second operand for immediate rows
    } row_t;

    localparam cpuPkg::word_t blankWord = 32'hdead_beef;
    localparam cpuPkg::word_t markVal   = 32'h0000_05a5;
    localparam int pollLimit = 50;

    logic            clk = 1'b0;
    logic            rst;
    cpuPkg::apbReq_t apbIn;
    cpuPkg::apbRsp_t apbOut;
    int              mismatches = 0;
    int              timeouts = 0;
    cpuPkg::word_t   prog [$];
    row_t            rows [$];
    opKind_e regKinds [10] = '{aluAdd, aluSub, aluSll, aluSlt, aluSltu,
                               aluXor, aluSrl, aluSra, aluOr, aluAnd};
    opKind_e immKinds [9] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor,
                              aluSrl, aluSra, aluOr, aluAnd};
    opKind_e brKinds [6] = '{brEq, brNe, brLt, brGe, brLtu, brGeu};

    cpuTop i_cpuTop (
        .clk    (clk),
        .rst    (rst),
        .apbIn  (apbIn),
        .apbOut (apbOut)
    );

    always #50 clk = ~clk;

    function automatic cpuPkg::word_t encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpuPkg::opAluReg};
    endfunction

    function automatic cpuPkg::word_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic cpuPkg::word_t encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, cpuPkg::f3Word, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::word_t encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::opBranch};
    endfunction

    function automatic cpuPkg::word_t encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic cpuPkg::word_t encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpuPkg::opJal};
    endfunction

    function automatic logic [2:0] funct3Of(opKind_e k);
        case (k)
            aluAdd, aluSub, brEq: return cpuPkg::f3Add;
            aluSll, brNe:         return cpuPkg::f3Sll;
            aluSlt:               return cpuPkg::f3Slt;
            aluSltu:              return cpuPkg::f3Sltu;
            aluXor, brLt:         return cpuPkg::f3Xor;
            aluSrl, aluSra, brGe: return cpuPkg::f3Srl;
            aluOr, brLtu:         return cpuPkg::f3Or;
            default:              return cpuPkg::f3And;   // and, bgeu
        endcase
    endfunction

    // RV32I result rules, b is rs2 or the sign-extended immediate
    function automatic cpuPkg::word_t aluRule(opKind_e k, cpuPkg::word_t a, cpuPkg::word_t b);
        case (k)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluSll:  return a << b[4:0];
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluXor:  return a ^ b;
            aluSrl:  return a >> b[4:0];
            aluSra:  return $signed(a) >>> b[4:0];
            aluOr:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(opKind_e k, cpuPkg::word_t a, cpuPkg::word_t b);
        case (k)
            brEq:    return a == b;
            brNe:    return a != b;
            brLt:    return $signed(a) < $signed(b);
            brGe:    return $signed(a) >= $signed(b);
            brLtu:   return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkWord(input string what, input cpuPkg::word_t got,
                             input cpuPkg::word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s read 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    // setup cycle, access cycle, then idle; sampled mid access cycle
    task automatic apbXfer(input logic write, input logic [11:0] addr, input cpuPkg::word_t wdata,
                           output cpuPkg::word_t rdata, input logic expErr);
        @(posedge clk);
        #1;
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = write;
        apbIn.paddr   = addr;
        apbIn.pwdata  = wdata;
        @(posedge clk);
        #1;
        apbIn.penable = 1'b1;
        #40;
        rdata = apbOut.prdata;
        if (apbOut.pready !== 1'b1) begin
            mismatches++;
            $display("mismatch at %0t ns: pready %b at address 0x%h, expected 1",
                     $time, apbOut.pready, addr);
        end
        if (apbOut.pslverr !== expErr) begin
            mismatches++;
            $display("mismatch at %0t ns: pslverr %b at address 0x%h, expected %b",
                     $time, apbOut.pslverr, addr, expErr);
        end
        @(posedge clk);
        #1;
        apbIn.psel    = 1'b0;
        apbIn.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input cpuPkg::word_t data, input logic expErr);
        cpuPkg::word_t unused;
        apbXfer(1'b1, addr, data, unused, expErr);
    endtask

    task automatic apbRead(input logic [11:0] addr, output cpuPkg::word_t data, input logic expErr);
        apbXfer(1'b0, addr, 32'h0, data, expErr);
    endtask

    task automatic loadConst(input logic [4:0] rd, input cpuPkg::word_t v);
        cpuPkg::word_t upper;
        upper = v + 32'h800;   // addi sign-extends the low part
        prog.push_back(encU(upper[31:12], rd, cpuPkg::opLui));
        prog.push_back(encI(v[11:0], rd, cpuPkg::f3Add, rd, cpuPkg::opAluImm));
    endtask

    task automatic clearData();
        for (int i = 0; i < 12; i++) begin
            apbWrite(cpuPkg::dmemBase + 12'(4 * i), blankWord, 1'b0);
        end
    endtask

    task automatic loadProgram();
        prog.push_back(32'h0);   // illegal word ends every program
        foreach (prog[i]) begin
            apbWrite(cpuPkg::imemBase + 12'(4 * i), prog[i], 1'b0);
        end
    endtask

    task automatic runToHalt(output cpuPkg::word_t status);
        int polls;
        polls = 0;
        status = '0;
        apbWrite(cpuPkg::ctrlAddr, 32'd1, 1'b0);
        while (!status[1] && polls < pollLimit) begin
            apbRead(cpuPkg::ctrlAddr, status, 1'b0);
            polls++;
        end
        if (!status[1]) begin
            timeouts++;
            $display("core did not halt within %0d status polls at %0t ns", pollLimit, $time);
        end
        apbWrite(cpuPkg::ctrlAddr, 32'd0, 1'b0);
    endtask

    task automatic addRow(input opKind_e k, input logic useImm, input cpuPkg::word_t a,
                          input cpuPkg::word_t b);
        row_t r;
        r.kind   = k;
        r.useImm = useImm;
        r.a      = a;
        r.b      = b;
        rows.push_back(r);
    endtask

    task automatic runRow(input row_t r);
        cpuPkg::word_t expWord;
        cpuPkg::word_t got;
        cpuPkg::word_t status;
        logic [6:0]    f7;
        opKind_e       kind;
        string         label;
        kind  = r.kind;
        label = kind.name();
        if (r.useImm) begin
            label = {label, " imm"};
        end
        clearData();
        prog.delete();
        if (r.kind inside {brEq, brNe, brLt, brGe, brLtu, brGeu}) begin
            loadConst(5'd1, r.a);
            loadConst(5'd2, r.b);
            prog.push_back(encI(markVal[11:0], 5'd0, cpuPkg::f3Add, 5'd4, cpuPkg::opAluImm));
            prog.push_back(encB(13'd8, 5'd2, 5'd1, funct3Of(r.kind)));
            prog.push_back(encS(12'd0, 5'd4, 5'd0));   // not-taken path only
            expWord = branchTaken(r.kind, r.a, r.b) ? blankWord : markVal;
        end else if (r.kind == jmpJal) begin
            prog.push_back(encJ(21'd8, 5'd3));
            prog.push_back(32'h0);
            prog.push_back(encS(12'd0, 5'd3, 5'd0));
            expWord = 32'd4;
        end else if (r.kind == jmpJalr) begin
            loadConst(5'd1, 32'd13);
            prog.push_back(encI(12'd4, 5'd1, 3'b000, 5'd3, cpuPkg::opJalr));   // 17 -> 16
            prog.push_back(32'h0);
            prog.push_back(encS(12'd0, 5'd3, 5'd0));
            expWord = 32'd12;
        end else if (r.kind == upAuipc) begin
            prog.push_back(encI(12'd0, 5'd0, cpuPkg::f3Add, 5'd0, cpuPkg::opAluImm));
            prog.push_back(encU(r.a[31:12], 5'd3, cpuPkg::opAuipc));
            prog.push_back(encS(12'd0, 5'd3, 5'd0));
            expWord = 32'd4 + {r.a[31:12], 12'b0};
        end else begin
            f7 = (r.kind inside {aluSub, aluSra}) ? cpuPkg::f7Alt : 7'b0;
            loadConst(5'd1, r.a);
            if (!r.useImm) begin
                loadConst(5'd2, r.b);
                prog.push_back(encR(f7, 5'd2, 5'd1, funct3Of(r.kind), 5'd3));
            end else if (r.kind inside {aluSll, aluSrl, aluSra}) begin
                prog.push_back(encI({f7, r.b[4:0]}, 5'd1, funct3Of(r.kind), 5'd3,
                                    cpuPkg::opAluImm));
            end else begin
                prog.push_back(encI(r.b[11:0], 5'd1, funct3Of(r.kind), 5'd3, cpuPkg::opAluImm));
            end
            prog.push_back(encS(12'd0, 5'd3, 5'd0));
            expWord = aluRule(r.kind, r.a, r.b);
        end
        loadProgram();
        runToHalt(status);
        apbRead(cpuPkg::dmemBase, got, 1'b0);
        checkWord(label, got, expWord);
    endtask

    task automatic memoryReadback();
        cpuPkg::word_t iImg [cpuPkg::imemWords];
        cpuPkg::word_t dImg [cpuPkg::dmemWords];
        cpuPkg::word_t got;
        foreach (iImg[i]) begin
            iImg[i] = $urandom();
            apbWrite(cpuPkg::imemBase + 12'(4 * i), iImg[i], 1'b0);
        end
        foreach (dImg[i]) begin
            dImg[i] = $urandom();
            apbWrite(cpuPkg::dmemBase + 12'(4 * i), dImg[i], 1'b0);
        end
        foreach (iImg[i]) begin
            apbRead(cpuPkg::imemBase + 12'(4 * i), got, 1'b0);
            checkWord("imem readback", got, iImg[i]);
        end
        foreach (dImg[i]) begin
            apbRead(cpuPkg::dmemBase + 12'(4 * i), got, 1'b0);
            checkWord("dmem readback", got, dImg[i]);
        end
    endtask

    task automatic loadStoreCase();
        cpuPkg::word_t v;
        cpuPkg::word_t got;
        cpuPkg::word_t status;
        v = $urandom();
        clearData();
        prog.delete();
        loadConst(5'd1, v);
        prog.push_back(encI(12'd16, 5'd0, cpuPkg::f3Add, 5'd2, cpuPkg::opAluImm));
        prog.push_back(encS(12'd8, 5'd1, 5'd2));   // word 6
        prog.push_back(encI(12'd8, 5'd2, cpuPkg::f3Word, 5'd5, cpuPkg::opLoad));
        prog.push_back(encS(12'd40, 5'd5, 5'd0));   // word 10
        loadProgram();
        runToHalt(status);
        apbRead(cpuPkg::dmemBase + 12'd24, got, 1'b0);
        checkWord("sw before lw", got, v);
        apbRead(cpuPkg::dmemBase + 12'd40, got, 1'b0);
        checkWord("sw after lw", got, v);
    endtask

    // bad word sits at pc 8 between two stores
    task automatic haltCase(input string what, input cpuPkg::word_t badWord);
        cpuPkg::word_t got;
        cpuPkg::word_t status;
        clearData();
        prog.delete();
        prog.push_back(encI(12'h077, 5'd0, cpuPkg::f3Add, 5'd1, cpuPkg::opAluImm));
        prog.push_back(encS(12'd4, 5'd1, 5'd0));
        prog.push_back(badWord);
        prog.push_back(encS(12'd8, 5'd1, 5'd0));
        loadProgram();
        runToHalt(status);
        checkWord({what, " status"}, status, 32'd3);   // run and halted both set
        apbRead(cpuPkg::pcAddr, got, 1'b0);
        checkWord({what, " pc"}, got, 32'd8);
        apbRead(cpuPkg::dmemBase + 12'd4, got, 1'b0);
        checkWord({what, " store before"}, got, 32'h77);
        apbRead(cpuPkg::dmemBase + 12'd8, got, 1'b0);
        checkWord({what, " store after"}, got, blankWord);
    endtask

    task automatic busErrorCase();
        cpuPkg::word_t got;
        prog.delete();
        prog.push_back(encJ(21'd0, 5'd0));   // spins on itself
        loadProgram();
        apbWrite(cpuPkg::ctrlAddr, 32'd1, 1'b0);
        apbRead(cpuPkg::dmemBase, got, 1'b1);
        apbWrite(cpuPkg::imemBase, 32'h0, 1'b1);
        apbWrite(cpuPkg::pcAddr, 32'h10, 1'b1);
        apbRead(cpuPkg::pcAddr, got, 1'b0);
        checkWord("pc while spinning", got, 32'd0);
        apbWrite(cpuPkg::ctrlAddr, 32'd0, 1'b0);
        apbRead(cpuPkg::imemBase, got, 1'b0);
        checkWord("imem after blocked write", got, encJ(21'd0, 5'd0));
        apbRead(12'hc00, got, 1'b1);   // unmapped
    endtask

    initial begin
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        void'($urandom(32'hfc4a_dcf7));
        rst = 1'b0;
        apbIn = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        foreach (regKinds[i]) begin
            a = $urandom();
            b = $urandom();
            addRow(regKinds[i], 1'b0, a, b);
        end
        foreach (immKinds[i]) begin
            a = $urandom();
            b = $urandom();
            if (immKinds[i] inside {aluSll, aluSrl, aluSra}) begin
                b = b & 32'd31;
            end else begin
                b = {{20{b[11]}}, b[11:0]};
            end
            addRow(immKinds[i], 1'b1, a, b);
        end
        foreach (brKinds[i]) begin
            a = $urandom();
            b = $urandom();
            addRow(brKinds[i], 1'b0, a, b);
            addRow(brKinds[i], 1'b0, a, a);   // equal operands
        end
        addRow(jmpJal, 1'b0, 32'd0, 32'd0);
        addRow(jmpJalr, 1'b0, 32'd0, 32'd0);
        a = $urandom();
        addRow(upAuipc, 1'b0, a, 32'd0);

        memoryReadback();
        foreach (rows[i]) begin
            runRow(rows[i]);
        end
        loadStoreCase();
        haltCase("illegal opcode", 32'hffff_ffff);
        haltCase("misaligned lw", encI(12'd2, 5'd0, cpuPkg::f3Word, 5'd3, cpuPkg::opLoad));
        haltCase("illegal funct7", encR(7'b0000001, 5'd2, 5'd1, cpuPkg::f3Add, 5'd3));
        busErrorCase();

        $display("%0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
source/cpuPkg.sv
source/instrDecode.sv
source/regFile.sv
source/aluExec.sv
source/nextPc.sv
source/wordMem.sv
source/apbRegs.sv
source/cpuCore.sv
source/cpuTop.sv
bench/cpuAssert_assert.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f sim.f --top-module cpuTb -o cpuSim
simOut=$(./obj_dir/cpuSim)
echo "$simOut"
if echo "$simOut" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
